/* Bender.yml */
package:
  name: m6502

sources:
  - files:
      - common/cpu_pkg.sv
      - alu/m6502_alu.sv
      - src/instr_fetch.sv
      - src/instr_decode.sv
      - src/mem_access.sv
      - src/execute_unit.sv
      - src/m6502_top.sv
  - target: test
    files:
      - test/mem_model.sv
      - test/tb_m6502.sv

/* alu/m6502_alu.sv */
module m6502_alu
   import cpu_pkg::*;
(
   input  logic              clk,
   input  logic              reset_n,
   input  logic              alu_en_i,
   input  alu_op_t           alu_op_i,
   input  logic [DATA_W-1:0] a_i,
   input  logic [DATA_W-1:0] b_i,
   output logic [DATA_W-1:0] result_o,
   output logic              flag_n_o,
   output logic              flag_z_o,
   output logic              flag_c_o,
   output logic              flag_v_o
);

   logic [DATA_W:0]   sum;
   logic [DATA_W:0]   diff;
   logic [DATA_W-1:0] res;
   logic              c_next;
   logic              v_next;

   always_comb
   begin
      sum    = {1'b0, a_i} + {1'b0, b_i} + {{DATA_W{1'b0}}, flag_c_o};
      diff   = {1'b0, a_i} - {1'b0, b_i};
      c_next = flag_c_o;
      v_next = flag_v_o;
      case (alu_op_i)
         ALU_OR:  res = a_i | b_i;
         ALU_AND: res = a_i & b_i;
         ALU_EOR: res = a_i ^ b_i;
         ALU_ADC:
         begin
            res    = sum[DATA_W-1:0];
            c_next = sum[DATA_W];
            v_next = (a_i[DATA_W-1] == b_i[DATA_W-1]) && (res[DATA_W-1] != a_i[DATA_W-1]);
         end
         ALU_CMP:
         begin
            res    = diff[DATA_W-1:0];
            c_next = !diff[DATA_W]; // No borrow means a >= b
         end
         default: res = b_i;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (!reset_n)
      begin
         flag_n_o <= 1'b0;
         flag_z_o <= 1'b0;
         flag_c_o <= 1'b0;
         flag_v_o <= 1'b0;
      end
      else if (alu_en_i)
      begin
         flag_n_o <= res[DATA_W-1];
         flag_z_o <= (res == '0);
         flag_c_o <= c_next;
         flag_v_o <= v_next;
      end
   end

   always_ff @(posedge clk)
   begin
      if (alu_en_i)
         result_o <= res;
   end

endmodule

/* common/cpu_pkg.sv */
package cpu_pkg;

   localparam int ADDR_W = 16;
   localparam int DATA_W = 8;

   localparam logic [ADDR_W-1:0] RESET_VECTOR = 16'hFFFC; // Low byte, high byte follows

   // Operation after decode
   typedef enum logic [3:0]
   {
      OP_NOP,
      OP_LDA,
      OP_STA,
      OP_ORA,
      OP_AND,
      OP_EOR,
      OP_ADC,
      OP_SBC,
      OP_CMP,
      OP_BRANCH
   } cpu_op_t;

   typedef enum logic [1:0]
   {
      MODE_NONE,
      MODE_IMM,
      MODE_ZP,
      MODE_ABS
   } addr_mode_t;

   typedef enum logic [2:0]
   {
      ALU_PASS, // Result is operand b
      ALU_OR,
      ALU_AND,
      ALU_EOR,
      ALU_ADC,
      ALU_CMP   // a minus b, flags only
   } alu_op_t;

endpackage

/* src.f */
common/cpu_pkg.sv
alu/m6502_alu.sv
src/instr_fetch.sv
src/instr_decode.sv
src/mem_access.sv
src/execute_unit.sv
src/m6502_top.sv
test/mem_model.sv
test/tb_m6502.sv

/* src/execute_unit.sv */
module execute_unit
   import cpu_pkg::*;
(
   input  logic              clk,
   input  logic              reset_n,
   input  cpu_op_t           op_i,
   input  logic [2:0]        cond_i,
   input  logic [DATA_W-1:0] operand_i,
   input  logic              operand_valid_i,
   output logic [DATA_W-1:0] acc_o,
   output logic              instr_done_o,
   output logic              branch_taken_o
);

   alu_op_t           alu_op;
   logic              is_alu;
   logic              alu_en;
   logic              alu_pending;
   logic [DATA_W-1:0] alu_b;
   logic [DATA_W-1:0] alu_result;
   logic              flag_n;
   logic              flag_z;
   logic              flag_c;
   logic              flag_v;
   logic              flag_sel;

   always_comb
   begin
      is_alu = 1'b1;
      alu_op = ALU_PASS;
      case (op_i)
         OP_LDA: alu_op = ALU_PASS;
         OP_ORA: alu_op = ALU_OR;
         OP_AND: alu_op = ALU_AND;
         OP_EOR: alu_op = ALU_EOR;
         OP_ADC: alu_op = ALU_ADC;
         OP_SBC: alu_op = ALU_ADC; // With inverted operand
         OP_CMP: alu_op = ALU_CMP;
         default: is_alu = 1'b0;
      endcase
   end

   assign alu_b  = (op_i == OP_SBC) ? ~operand_i : operand_i;
   assign alu_en = operand_valid_i && is_alu;

   // Pairs N, V, C, Z; low bit picks set or clear
   always_comb
   begin
      case (cond_i[2:1])
         2'b00: flag_sel = flag_n;
         2'b01: flag_sel = flag_v;
         2'b10: flag_sel = flag_c;
         default: flag_sel = flag_z;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (!reset_n)
      begin
         acc_o          <= '0;
         alu_pending    <= 1'b0;
         instr_done_o   <= 1'b0;
         branch_taken_o <= 1'b0;
      end
      else
      begin
         instr_done_o <= 1'b0;
         alu_pending  <= alu_en;
         if (alu_pending)
         begin
            if (op_i != OP_CMP)
               acc_o <= alu_result;
            instr_done_o   <= 1'b1;
            branch_taken_o <= 1'b0;
         end
         else if (operand_valid_i && !is_alu)
         begin
            instr_done_o   <= 1'b1;
            branch_taken_o <= (op_i == OP_BRANCH) && (flag_sel == cond_i[0]);
         end
      end
   end

   m6502_alu u_alu (
      .clk      (clk),
      .reset_n  (reset_n),
      .alu_en_i (alu_en),
      .alu_op_i (alu_op),
      .a_i      (acc_o),
      .b_i      (alu_b),
      .result_o (alu_result),
      .flag_n_o (flag_n),
      .flag_z_o (flag_z),
      .flag_c_o (flag_c),
      .flag_v_o (flag_v)
   );

endmodule

/* src/instr_decode.sv */
module instr_decode
   import cpu_pkg::*;
(
   input  logic              clk,
   input  logic              reset_n,
   input  logic [DATA_W-1:0] opcode_i,
   input  logic              opcode_valid_i,
   output cpu_op_t           op_o,
   output addr_mode_t        mode_o,
   output logic [1:0]        length_o,
   output logic [2:0]        cond_o,
   output logic              decoded_valid_o
);

   logic [2:0] aaa;
   logic [2:0] bbb;
   logic [1:0] cc;
   cpu_op_t    dec_op;
   addr_mode_t dec_mode;
   logic [1:0] dec_len;

   assign aaa = opcode_i[7:5];
   assign bbb = opcode_i[4:2];
   assign cc  = opcode_i[1:0];

   always_comb
   begin
      dec_op   = OP_NOP;
      dec_mode = MODE_NONE;
      dec_len  = 2'd1;
      if (cc == 2'b01 && (bbb == 3'd1 || bbb == 3'd2 || bbb == 3'd3))
      begin
         case (aaa)
            3'b000: dec_op = OP_ORA;
            3'b001: dec_op = OP_AND;
            3'b010: dec_op = OP_EOR;
            3'b011: dec_op = OP_ADC;
            3'b100: dec_op = OP_STA;
            3'b101: dec_op = OP_LDA;
            3'b110: dec_op = OP_CMP;
            default: dec_op = OP_SBC;
         endcase
         case (bbb)
            3'd1: dec_mode = MODE_ZP;
            3'd2: dec_mode = MODE_IMM;
            default: dec_mode = MODE_ABS;
         endcase
         dec_len = (bbb == 3'd3) ? 2'd3 : 2'd2;
         if (dec_op == OP_STA && dec_mode == MODE_IMM)
         begin
            dec_op   = OP_NOP; // Undefined, skip the operand byte
            dec_mode = MODE_NONE;
         end
      end
      else if (cc == 2'b00 && bbb == 3'b100)
      begin
         dec_op   = OP_BRANCH;
         dec_mode = MODE_IMM; // Offset byte
         dec_len  = 2'd2;
      end
   end

   always_ff @(posedge clk)
   begin
      if (!reset_n)
         decoded_valid_o <= 1'b0;
      else
         decoded_valid_o <= opcode_valid_i;
   end

   always_ff @(posedge clk)
   begin
      if (opcode_valid_i)
      begin
         op_o     <= dec_op;
         mode_o   <= dec_mode;
         length_o <= dec_len;
         cond_o   <= aaa;
      end
   end

   a_len_mode: assert property (@(posedge clk) disable iff (!reset_n)
      decoded_valid_o |->
         ((mode_o == MODE_ABS) ? (length_o == 2'd3) :
          (mode_o == MODE_NONE) ? (length_o == 2'd1 ||
                                   (length_o == 2'd2 && cond_o == 3'b100)) :
          (length_o == 2'd2)));

endmodule

/* src/instr_fetch.sv */
module instr_fetch
   import cpu_pkg::*;
(
   input  logic              clk,
   input  logic              reset_n,
   input  logic              ready_i,
   input  logic [DATA_W-1:0] rd_data_i,
   input  logic [1:0]        length_i,
   input  logic              instr_done_i,
   input  logic              branch_taken_i,
   input  logic [DATA_W-1:0] operand_i,
   output logic [ADDR_W-1:0] pc_o,
   output logic [ADDR_W-1:0] fetch_addr_o,
   output logic              fetch_rd_req_o,
   output logic [DATA_W-1:0] opcode_o,
   output logic              opcode_valid_o
);

   typedef enum logic [2:0]
   {
      F_INIT,
      F_START,
      F_VEC_LO,
      F_VEC_HI,
      F_FETCH,
      F_WAIT_DONE
   } fetch_state_t;

   fetch_state_t      state;
   logic [ADDR_W-1:0] next_pc;

   always_comb
   begin
      next_pc = pc_o + {{(ADDR_W-2){1'b0}}, length_i};
      if (branch_taken_i)
         next_pc = next_pc + {{(ADDR_W-DATA_W){operand_i[DATA_W-1]}}, operand_i}; // Signed offset
   end

   always_ff @(posedge clk)
   begin
      if (!reset_n)
      begin
         state          <= F_INIT;
         fetch_rd_req_o <= 1'b0;
         opcode_valid_o <= 1'b0;
      end
      else
      begin
         fetch_rd_req_o <= 1'b0;
         opcode_valid_o <= 1'b0;
         case (state)
            F_INIT: state <= F_START;
            F_START:
            begin
               fetch_addr_o   <= RESET_VECTOR;
               fetch_rd_req_o <= 1'b1;
               state          <= F_VEC_LO;
            end
            F_VEC_LO:
               if (ready_i)
               begin
                  pc_o[DATA_W-1:0] <= rd_data_i;
                  fetch_addr_o     <= RESET_VECTOR + ADDR_W'(1);
                  fetch_rd_req_o   <= 1'b1;
                  state            <= F_VEC_HI;
               end
            F_VEC_HI:
               if (ready_i)
               begin
                  pc_o           <= {rd_data_i, pc_o[DATA_W-1:0]};
                  fetch_addr_o   <= {rd_data_i, pc_o[DATA_W-1:0]};
                  fetch_rd_req_o <= 1'b1;
                  state          <= F_FETCH;
               end
            F_FETCH:
               if (ready_i)
               begin
                  opcode_o       <= rd_data_i;
                  opcode_valid_o <= 1'b1;
                  state          <= F_WAIT_DONE;
               end
            F_WAIT_DONE:
               if (instr_done_i)
               begin
                  pc_o           <= next_pc;
                  fetch_addr_o   <= next_pc;
                  fetch_rd_req_o <= 1'b1;
                  state          <= F_FETCH;
               end
            default: state <= F_INIT;
         endcase
      end
   end

   a_req_pulse: assert property (@(posedge clk) disable iff (!reset_n)
      fetch_rd_req_o |=> !fetch_rd_req_o);

endmodule

/* src/m6502_top.sv */
module m6502_top
   import cpu_pkg::*;
(
   input  logic              clk,
   input  logic              reset_n,
   output logic [ADDR_W-1:0] addr_o,
   input  logic [DATA_W-1:0] rd_data_i,
   output logic [DATA_W-1:0] wr_data_o,
   output logic              wr_en_o,
   output logic              rd_req_o,
   input  logic              ready_i
);

   logic [ADDR_W-1:0] pc;
   logic [ADDR_W-1:0] fetch_addr;
   logic              fetch_rd_req;
   logic [DATA_W-1:0] opcode;
   logic              opcode_valid;
   cpu_op_t           op;
   addr_mode_t        mode;
   logic [1:0]        length;
   logic [2:0]        cond;
   logic              decoded_valid;
   logic [DATA_W-1:0] operand;
   logic              operand_valid;
   logic [DATA_W-1:0] acc;
   logic              instr_done;
   logic              branch_taken;

   instr_fetch u_fetch (
      .clk            (clk),
      .reset_n        (reset_n),
      .ready_i        (ready_i),
      .rd_data_i      (rd_data_i),
      .length_i       (length),
      .instr_done_i   (instr_done),
      .branch_taken_i (branch_taken),
      .operand_i      (operand),
      .pc_o           (pc),
      .fetch_addr_o   (fetch_addr),
      .fetch_rd_req_o (fetch_rd_req),
      .opcode_o       (opcode),
      .opcode_valid_o (opcode_valid)
   );

   instr_decode u_decode (
      .clk             (clk),
      .reset_n         (reset_n),
      .opcode_i        (opcode),
      .opcode_valid_i  (opcode_valid),
      .op_o            (op),
      .mode_o          (mode),
      .length_o        (length),
      .cond_o          (cond),
      .decoded_valid_o (decoded_valid)
   );

   mem_access u_mem (
      .clk             (clk),
      .reset_n         (reset_n),
      .pc_i            (pc),
      .op_i            (op),
      .mode_i          (mode),
      .decoded_valid_i (decoded_valid),
      .store_data_i    (acc),
      .fetch_addr_i    (fetch_addr),
      .fetch_rd_req_i  (fetch_rd_req),
      .rd_data_i       (rd_data_i),
      .ready_i         (ready_i),
      .addr_o          (addr_o),
      .rd_req_o        (rd_req_o),
      .wr_en_o         (wr_en_o),
      .wr_data_o       (wr_data_o),
      .operand_o       (operand),
      .operand_valid_o (operand_valid)
   );

   execute_unit u_exec (
      .clk             (clk),
      .reset_n         (reset_n),
      .op_i            (op),
      .cond_i          (cond),
      .operand_i       (operand),
      .operand_valid_i (operand_valid),
      .acc_o           (acc),
      .instr_done_o    (instr_done),
      .branch_taken_o  (branch_taken)
   );

endmodule

/* src/mem_access.sv */
module mem_access
   import cpu_pkg::*;
(
   input  logic              clk,
   input  logic              reset_n,
   input  logic [ADDR_W-1:0] pc_i,
   input  cpu_op_t           op_i,
   input  addr_mode_t        mode_i,
   input  logic              decoded_valid_i,
   input  logic [DATA_W-1:0] store_data_i,
   input  logic [ADDR_W-1:0] fetch_addr_i,
   input  logic              fetch_rd_req_i,
   input  logic [DATA_W-1:0] rd_data_i,
   input  logic              ready_i,
   output logic [ADDR_W-1:0] addr_o,
   output logic              rd_req_o,
   output logic              wr_en_o,
   output logic [DATA_W-1:0] wr_data_o,
   output logic [DATA_W-1:0] operand_o,
   output logic              operand_valid_o
);

   typedef enum logic [2:0]
   {
      MA_IDLE,
      MA_ZP,
      MA_ABS_LO,
      MA_ABS_HI,
      MA_READ,
      MA_WRITE
   } ma_state_t;

   ma_state_t         state;
   logic [ADDR_W-1:0] addr_q;
   logic              rd_req_q;
   logic              wr_en_q;
   logic [DATA_W-1:0] lo_q;
   logic [ADDR_W-1:0] eff_addr;
   logic              is_store;

   assign is_store = (op_i == OP_STA);
   assign eff_addr = (state == MA_ZP) ? {{(ADDR_W-DATA_W){1'b0}}, rd_data_i}
                                      : {rd_data_i, lo_q};

   // Fetch owns the port while idle
   assign addr_o   = (state == MA_IDLE) ? fetch_addr_i : addr_q;
   assign rd_req_o = fetch_rd_req_i | rd_req_q;
   assign wr_en_o  = wr_en_q;

   always_ff @(posedge clk)
   begin
      if (!reset_n)
      begin
         state           <= MA_IDLE;
         rd_req_q        <= 1'b0;
         wr_en_q         <= 1'b0;
         operand_valid_o <= 1'b0;
      end
      else
      begin
         rd_req_q        <= 1'b0;
         wr_en_q         <= 1'b0;
         operand_valid_o <= 1'b0;
         case (state)
            MA_IDLE:
               if (decoded_valid_i)
               begin
                  addr_q <= pc_i + ADDR_W'(1);
                  case (mode_i)
                     MODE_NONE: operand_valid_o <= 1'b1;
                     MODE_IMM:
                     begin
                        rd_req_q <= 1'b1;
                        state    <= MA_READ;
                     end
                     MODE_ZP:
                     begin
                        rd_req_q <= 1'b1;
                        state    <= MA_ZP;
                     end
                     default:
                     begin
                        rd_req_q <= 1'b1;
                        state    <= MA_ABS_LO;
                     end
                  endcase
               end
            MA_ABS_LO:
               if (ready_i)
               begin
                  lo_q     <= rd_data_i;
                  addr_q   <= pc_i + ADDR_W'(2);
                  rd_req_q <= 1'b1;
                  state    <= MA_ABS_HI;
               end
            MA_ZP, MA_ABS_HI:
               if (ready_i)
               begin
                  addr_q <= eff_addr;
                  if (is_store)
                  begin
                     wr_en_q         <= 1'b1;
                     wr_data_o       <= store_data_i;
                     operand_valid_o <= 1'b1; // Store completes with the write
                     state           <= MA_WRITE;
                  end
                  else
                  begin
                     rd_req_q <= 1'b1;
                     state    <= MA_READ;
                  end
               end
            MA_READ:
               if (ready_i)
               begin
                  operand_o       <= rd_data_i;
                  operand_valid_o <= 1'b1;
                  state           <= MA_IDLE;
               end
            MA_WRITE: state <= MA_IDLE;
            default: state <= MA_IDLE;
         endcase
      end
   end

   a_rd_wr_excl: assert property (@(posedge clk) disable iff (!reset_n)
      !(rd_req_o && wr_en_o));

endmodule

/* test/mem_model.sv */
module mem_model
   import cpu_pkg::*;
(
   input  logic              clk,
   input  logic              reset_n,
   input  logic [ADDR_W-1:0] addr_i,
   input  logic              rd_req_i,
   input  logic              wr_en_i,
   input  logic [DATA_W-1:0] wr_data_i,
   output logic [DATA_W-1:0] rd_data_o,
   output logic              ready_o,
   output int                wr_count_o
);
   timeunit 1ns;
   timeprecision 100ps;

   logic [DATA_W-1:0] mem [0:(1<<ADDR_W)-1];
   logic [ADDR_W-1:0] pend_addr;
   logic              pending;
   int                wait_cnt;

   initial
   begin
      ready_o   = 1'b0;
      rd_data_o = '0;
   end

   always @(negedge clk)
   begin
      if (!reset_n)
      begin
         ready_o    <= 1'b0;
         pending    <= 1'b0;
         wr_count_o <= 0;
      end
      else
      begin
         ready_o <= 1'b0;
         if (wr_en_i)
         begin
            mem[addr_i] <= wr_data_i;
            wr_count_o  <= wr_count_o + 1; // Write log
         end
         if (rd_req_i)
         begin
            pend_addr <= addr_i;
            wait_cnt  <= $urandom_range(4, 1) - 1; // 1 to 4 cycles
            pending   <= 1'b1;
         end
         else if (pending)
         begin
            if (wait_cnt == 0)
            begin
               ready_o   <= 1'b1;
               rd_data_o <= mem[pend_addr];
               pending   <= 1'b0;
            end
            else
               wait_cnt <= wait_cnt - 1;
         end
      end
   end

endmodule

/* test/tb_m6502.sv */
module tb_m6502
   import cpu_pkg::*;
();
   timeunit 1ns;
   timeprecision 100ps;

   logic              clk;
   logic              reset_n;
   logic [ADDR_W-1:0] addr;
   logic [DATA_W-1:0] rd_data;
   logic [DATA_W-1:0] wr_data;
   logic              wr_en;
   logic              rd_req;
   logic              ready;
   int                wr_count;

   logic [ADDR_W-1:0] exp_rd [$];
   logic [ADDR_W-1:0] exp_wa [$];
   logic [DATA_W-1:0] exp_wd [$];
   int                grp_end [$];
   string             grp_name [$];
   int                rd_seen;
   int                wr_seen;
   int                pass_cnt;
   int                fail_cnt;
   int                bus_fail;
   logic              busy;

   logic [ADDR_W-1:0] pc; // Reference model state
   logic [DATA_W-1:0] acc;
   logic              fn;
   logic              fz;
   logic              fc;
   logic              fv;
   int                zp_next;
   int                zp_st;
   int                abs_next;
   int                abs_st;

   m6502_top DUT (
      .clk       (clk),
      .reset_n   (reset_n),
      .addr_o    (addr),
      .rd_data_i (rd_data),
      .wr_data_o (wr_data),
      .wr_en_o   (wr_en),
      .rd_req_o  (rd_req),
      .ready_i   (ready)
   );

   mem_model u_mem (
      .clk        (clk),
      .reset_n    (reset_n),
      .addr_i     (addr),
      .rd_req_i   (rd_req),
      .wr_en_i    (wr_en),
      .wr_data_i  (wr_data),
      .rd_data_o  (rd_data),
      .ready_o    (ready),
      .wr_count_o (wr_count)
   );

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   task automatic put(input logic [7:0] b);
      u_mem.mem[pc] = b;
      pc = pc + 1;
   endtask

   task automatic alu_model(input logic [2:0] aaa, input logic [7:0] val);
      logic [8:0] s;
      logic [7:0] b;
      logic [7:0] r;
      b = (aaa == 3'b111) ? ~val : val; // SBC adds the complement
      r = acc;
      case (aaa)
         3'd0: r = acc | val;
         3'd1: r = acc & val;
         3'd2: r = acc ^ val;
         3'd3, 3'd7:
         begin
            s  = acc + b + fc;
            r  = s[7:0];
            fv = (acc[7] == b[7]) && (r[7] != acc[7]);
            fc = s[8];
         end
         3'd5: r = val;
         3'd6:
         begin
            r  = acc - val;
            fc = (acc >= val);
         end
         default: r = acc;
      endcase
      fn = r[7];
      fz = (r == 8'h00);
      if (aaa != 3'd6)
         acc = r;
   endtask

   // mode 0 immediate, 1 zero page, 2 absolute
   task automatic group_one(input logic [2:0] aaa, input int mode, input logic [7:0] val);
      logic [15:0] a;
      exp_rd.push_back(pc);
      if (mode == 0)
      begin
         put({aaa, 3'd2, 2'b01});
         exp_rd.push_back(pc);
         put(val);
      end
      else if (mode == 1)
      begin
         a = 16'(zp_next);
         zp_next++;
         u_mem.mem[a] = val;
         put({aaa, 3'd1, 2'b01});
         exp_rd.push_back(pc);
         put(a[7:0]);
         exp_rd.push_back(a);
      end
      else
      begin
         a = 16'(abs_next);
         abs_next++;
         u_mem.mem[a] = val;
         put({aaa, 3'd3, 2'b01});
         exp_rd.push_back(pc);
         put(a[7:0]);
         exp_rd.push_back(pc);
         put(a[15:8]);
         exp_rd.push_back(a);
      end
      alu_model(aaa, val);
   endtask

   task automatic store(input bit use_abs);
      logic [15:0] a;
      exp_rd.push_back(pc);
      if (use_abs)
      begin
         a = 16'(abs_st);
         abs_st++;
         put(8'h8D);
         exp_rd.push_back(pc);
         put(a[7:0]);
         exp_rd.push_back(pc);
         put(a[15:8]);
      end
      else
      begin
         a = 16'(zp_st);
         zp_st++;
         put(8'h85);
         exp_rd.push_back(pc);
         put(a[7:0]);
      end
      exp_wa.push_back(a);
      exp_wd.push_back(acc);
   endtask

   task automatic branch(input logic [2:0] cond, input logic [7:0] off);
      logic flag;
      case (cond[2:1])
         2'd0: flag = fn;
         2'd1: flag = fv;
         2'd2: flag = fc;
         default: flag = fz;
      endcase
      exp_rd.push_back(pc);
      put({cond, 3'b100, 2'b00});
      exp_rd.push_back(pc);
      put(off);
      if (flag == cond[0])
         pc = pc + {{8{off[7]}}, off};
   endtask

   // Puts the flag chosen by cond into state f
   task automatic set_flag(input logic [2:0] cond, input logic f);
      case (cond[2:1])
         2'd0: group_one(3'd5, 0, f ? 8'h80 : 8'h01);
         2'd1:
         begin
            group_one(3'd5, 0, 8'h00);
            group_one(3'd6, 0, 8'h01); // Clears C
            group_one(3'd5, 0, f ? 8'h7F : 8'h01);
            group_one(3'd3, 0, 8'h01);
         end
         2'd2:
         begin
            group_one(3'd5, 0, 8'h40);
            group_one(3'd6, 0, f ? 8'h10 : 8'h50);
         end
         default: group_one(3'd5, 0, f ? 8'h00 : 8'h01);
      endcase
   endtask

   task automatic end_group(input string name);
      grp_end.push_back(exp_rd.size() + 1); // Done at the next opcode read
      grp_name.push_back(name);
   endtask

   task automatic build_program();
      logic [2:0] ops [4];
      ops = '{3'd5, 3'd0, 3'd1, 3'd2};
      for (int i = 0; i < (1 << ADDR_W); i++)
         u_mem.mem[i] = 8'(i) ^ 8'(i >> 8) ^ 8'h5A;
      u_mem.mem[16'hFFFC] = 8'h34;
      u_mem.mem[16'hFFFD] = 8'h02;
      exp_rd.push_back(16'hFFFC);
      exp_rd.push_back(16'hFFFD);
      pc = 16'h0234;
      grp_end.push_back(3);
      grp_name.push_back("reset vector");
      for (int k = 0; k < 4; k++)
         for (int m = 0; m < 3; m++)
         begin
            group_one(ops[k], m, 8'($urandom()));
            store((k + m) % 2 == 1);
         end
      end_group("load and logic");
      group_one(3'd5, 0, 8'($urandom()));
      for (int k = 0; k < 12; k++)
      begin
         group_one(($urandom() % 2) ? 3'd3 : 3'd7, $urandom_range(2, 0), 8'($urandom()));
         store(k % 2 == 0);
      end
      end_group("adc and sbc");
      for (int c = 0; c < 8; c++)
         for (int t = 0; t < 2; t++)
         begin
            set_flag(3'(c), (t == 1) ? c[0] : !c[0]);
            branch(3'(c), 8'($urandom_range(6, 1)));
         end
      end_group("branches");
      exp_rd.push_back(pc);
      put(8'hEA); // Unsupported, one byte
      exp_rd.push_back(pc);
      put(8'h89); // STA immediate
      put(8'hA5);
      end_group("no-op opcodes");
      exp_rd.push_back(pc);
      for (int k = 0; k < 8; k++)
         put(8'hEA);
   endtask

   always @(negedge clk)
   begin
      if (reset_n && rd_req)
      begin
         if (rd_seen < exp_rd.size())
            assert (addr == exp_rd[rd_seen]) pass_cnt++;
            else
            begin
               fail_cnt++;
               $display("[FAIL] addr_o read %0d: got %h expected %h", rd_seen, addr,
                        exp_rd[rd_seen]);
            end
         rd_seen++;
      end
      if (reset_n && wr_en)
      begin
         if (wr_seen < exp_wa.size())
         begin
            assert (addr == exp_wa[wr_seen]) pass_cnt++;
            else
            begin
               fail_cnt++;
               $display("[FAIL] addr_o write %0d: got %h expected %h", wr_seen, addr,
                        exp_wa[wr_seen]);
            end
            assert (wr_data == exp_wd[wr_seen]) pass_cnt++;
            else
            begin
               fail_cnt++;
               $display("[FAIL] wr_data_o write %0d: got %h expected %h", wr_seen, wr_data,
                        exp_wd[wr_seen]);
            end
         end
         else
         begin
            fail_cnt++;
            $display("Write that the program does not contain, at address %h", addr);
         end
         wr_seen++;
      end
   end

   always @(posedge clk)
   begin
      if (!reset_n)
         busy <= 1'b0;
      else
         busy <= rd_req || (busy && !ready); // Read outstanding
   end

   a_rd_wr: assert property (@(posedge clk) disable iff (!reset_n) !(rd_req && wr_en))
      else
      begin
         fail_cnt++;
         bus_fail++;
         $display("Read request and write enable were high in the same cycle");
      end

   a_one_read: assert property (@(posedge clk) disable iff (!reset_n) rd_req |-> !busy)
      else
      begin
         fail_cnt++;
         bus_fail++;
         $display("New read request while a read was still outstanding");
      end

   initial
   begin
      int cycles;
      int fails_before;
      bit timed_out;
      reset_n   = 1'b0;
      rd_seen   = 0;
      wr_seen   = 0;
      pass_cnt  = 0;
      fail_cnt  = 0;
      bus_fail  = 0;
      timed_out = 1'b0;
      acc       = 8'h00;
      {fn, fz, fc, fv} = 4'b0000;
      zp_next   = 16'h0010;
      zp_st     = 16'h0080;
      abs_next  = 16'h3000;
      abs_st    = 16'h4000;
      void'($urandom(39));
      build_program();
      repeat (4) @(posedge clk);
      @(negedge clk);
      reset_n = 1'b1;
      for (int g = 0; g < grp_end.size() && !timed_out; g++)
      begin
         fails_before = fail_cnt;
         cycles = 0;
         while (rd_seen < grp_end[g] && cycles < 4000)
         begin
            @(posedge clk);
            cycles++;
         end
         if (rd_seen < grp_end[g])
         begin
            $display("Timeout: test %0d (%s) did not reach its next opcode read", g + 1,
                     grp_name[g]);
            timed_out = 1'b1;
         end
         else
            $display("test %0d %s: %0d errors", g + 1, grp_name[g], fail_cnt - fails_before);
      end
      if (timed_out)
      begin
         $display("Verification failed");
         $finish;
      end
      else
      begin
         @(posedge clk);
         assert (wr_count == exp_wa.size()) pass_cnt++;
         else
         begin
            fail_cnt++;
            $display("Memory saw %0d writes, the program makes %0d", wr_count, exp_wa.size());
         end
         $display("test %0d bus protocol: %0d errors", grp_end.size() + 1, bus_fail);
         $display("checks passed %0d, failed %0d", pass_cnt, fail_cnt);
         if (fail_cnt == 0)
            $display("Verification passed");
         else
            $display("Verification failed");
         $finish;
      end
   end

endmodule
